/* alu_top.f */
+incdir+rtl
rtl/alu_pkg.sv
rtl/alu_if.sv
rtl/alu_decode.sv
rtl/alu_execute.sv
rtl/alu_result.sv
rtl/alu_top.sv
tests/tb_clk_gen.sv
tests/alu_top_tb.sv

/* rtl/alu_decode.sv */
// opcode and vector mode decoder of the simd alu
// drives every control level of alu_ctrl_if

`timescale 1ns/1ps

module alu_decode (
  input  alu_pkg::alu_op_e   operator_i,
  input  alu_pkg::vec_mode_e vec_mode_i,
  input  logic               valid_i,
  input  logic               clk,
  input  logic               arst_n_i,
  alu_ctrl_if.decode         ctrl
);

  // operation compares lanes as signed values
  logic       signed_op;
  // top byte of every lane, for the current mode
  logic [3:0] lane_top;

  always_comb begin
    unique case (vec_mode_i)
      alu_pkg::VEC_MODE8:  lane_top = 4'b1111;
      alu_pkg::VEC_MODE16: lane_top = 4'b1010;
      default:             lane_top = 4'b1000;
    endcase
  end

  ////////////////////////////////////////
  // opcode map
  ////////////////////////////////////////

  always_comb begin
    // defaults give a plain unsigned add
    ctrl.negate_b    = 1'b0;
    ctrl.negate_a    = 1'b0;
    ctrl.shift_left  = 1'b0;
    ctrl.shift_arith = 1'b0;
    ctrl.rotate      = 1'b0;
    ctrl.cmp_kind    = 3'b001;
    ctrl.do_min      = 1'b0;
    ctrl.is_abs      = 1'b0;
    ctrl.logic_kind  = 2'b00;
    ctrl.res_sel     = alu_pkg::RES_ADDER;
    signed_op        = 1'b0;

    unique case (operator_i)
      // bitwise
      alu_pkg::ALU_AND: ctrl.res_sel = alu_pkg::RES_LOGIC;
      alu_pkg::ALU_OR: begin
        ctrl.logic_kind = 2'b01;
        ctrl.res_sel    = alu_pkg::RES_LOGIC;
      end
      alu_pkg::ALU_XOR: begin
        ctrl.logic_kind = 2'b10;
        ctrl.res_sel    = alu_pkg::RES_LOGIC;
      end

      // adder
      alu_pkg::ALU_ADD: ;
      alu_pkg::ALU_SUB: ctrl.negate_b = 1'b1;

      // shifter
      alu_pkg::ALU_SLL: begin
        ctrl.shift_left = 1'b1;
        ctrl.res_sel    = alu_pkg::RES_SHIFT;
      end
      alu_pkg::ALU_SRL: ctrl.res_sel = alu_pkg::RES_SHIFT;
      alu_pkg::ALU_SRA: begin
        ctrl.shift_arith = 1'b1;
        ctrl.res_sel     = alu_pkg::RES_SHIFT;
      end
      alu_pkg::ALU_ROR: begin
        ctrl.rotate  = 1'b1;
        ctrl.res_sel = alu_pkg::RES_SHIFT;
      end

      // comparisons
      alu_pkg::ALU_EQ, alu_pkg::ALU_NE: begin
        ctrl.cmp_kind = (operator_i == alu_pkg::ALU_NE) ? 3'b101 : 3'b001;
        ctrl.res_sel  = alu_pkg::RES_CMP;
      end
      alu_pkg::ALU_GTS, alu_pkg::ALU_GTU: begin
        ctrl.cmp_kind = 3'b010;
        ctrl.res_sel  = alu_pkg::RES_CMP;
        signed_op     = (operator_i == alu_pkg::ALU_GTS);
      end
      alu_pkg::ALU_GES, alu_pkg::ALU_GEU: begin
        ctrl.cmp_kind = 3'b011;
        ctrl.res_sel  = alu_pkg::RES_CMP;
        signed_op     = (operator_i == alu_pkg::ALU_GES);
      end
      // lt is not ge, le is not gt
      alu_pkg::ALU_LTS, alu_pkg::ALU_LTU: begin
        ctrl.cmp_kind = 3'b111;
        ctrl.res_sel  = alu_pkg::RES_CMP;
        signed_op     = (operator_i == alu_pkg::ALU_LTS);
      end
      alu_pkg::ALU_LES, alu_pkg::ALU_LEU: begin
        ctrl.cmp_kind = 3'b110;
        ctrl.res_sel  = alu_pkg::RES_CMP;
        signed_op     = (operator_i == alu_pkg::ALU_LES);
      end

      // min, max and abs share the lane mux
      alu_pkg::ALU_MIN, alu_pkg::ALU_MINU: begin
        ctrl.do_min  = 1'b1;
        ctrl.res_sel = alu_pkg::RES_MINMAX;
        signed_op    = (operator_i == alu_pkg::ALU_MIN);
      end
      alu_pkg::ALU_MAX, alu_pkg::ALU_MAXU: begin
        ctrl.res_sel = alu_pkg::RES_MINMAX;
        signed_op    = (operator_i == alu_pkg::ALU_MAX);
      end
      alu_pkg::ALU_ABS: begin
        // the adder forms 0 - a, the mux picks a or -a
        ctrl.negate_a = 1'b1;
        ctrl.negate_b = 1'b1;
        ctrl.is_abs   = 1'b1;
        ctrl.res_sel  = alu_pkg::RES_MINMAX;
        signed_op     = 1'b1;
      end

      default: ;
    endcase
  end

  assign ctrl.cmp_signed = signed_op ? lane_top : 4'b0000;
  assign ctrl.vec_mode   = vec_mode_i;

  // reserved mode must never arrive with a valid operation
  a_no_rsvd_mode : assert property (
    @(posedge clk) disable iff (!arst_n_i)
    valid_i |-> (vec_mode_i inside {alu_pkg::VEC_MODE32, alu_pkg::VEC_MODE16,
                                    alu_pkg::VEC_MODE8})
  );

endmodule

/* rtl/alu_execute.sv */
// execute stage of the simd alu, all combinational
// partitioned adder, bit-reversing shifter, lane comparator
// min/max/abs lane mux and bitwise logic

`timescale 1ns/1ps

`include "alu_macros.svh"

module alu_execute (
  input  alu_pkg::alu_word_t operand_a_i,
  input  alu_pkg::alu_word_t operand_b_i,
  alu_ctrl_if.execute        ctrl,
  alu_exec_if.execute        ex
);

  localparam int unsigned XLEN  = `ALU_XLEN;
  localparam int unsigned LANES = `ALU_LANES;
  localparam int unsigned LW    = `ALU_LANE_W;

  logic mode8;
  logic mode16;

  assign mode8  = (ctrl.vec_mode == alu_pkg::VEC_MODE8);
  assign mode16 = (ctrl.vec_mode == alu_pkg::VEC_MODE16);

  ////////////////////////////////////////
  // bitwise logic
  ////////////////////////////////////////

  always_comb begin
    unique case (ctrl.logic_kind)
      2'b01:   ex.logic_res = operand_a_i | operand_b_i;
      2'b10:   ex.logic_res = operand_a_i ^ operand_b_i;
      default: ex.logic_res = operand_a_i & operand_b_i;
    endcase
  end

  ////////////////////////////////////////
  // partitioned adder
  ////////////////////////////////////////

  alu_pkg::alu_word_t         add_op_a;
  alu_pkg::alu_word_t         add_op_b;
  // lane starts here, bit 0 is always a lane start
  logic [LANES-1:0]           lane_split;
  logic [XLEN+LANES-1:0]      add_in_a;
  logic [XLEN+LANES-1:0]      add_in_b;
  logic [XLEN+LANES-1:0]      add_sum;

  // abs forms ~a + 0 + 1
  assign add_op_a = ctrl.negate_a ? ~operand_a_i : operand_a_i;
  assign add_op_b = ctrl.is_abs ? '0 : (ctrl.negate_b ? ~operand_b_i : operand_b_i);

  assign lane_split = mode8 ? 4'b1111 : (mode16 ? 4'b0101 : 4'b0001);

  // guard bit below each byte
  // a=1 b=0 passes the carry, a=0 b=0 kills it, a=1 b=1 injects +1
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      add_in_a[(LW+1)*i]            = ctrl.negate_b | ~lane_split[i];
      add_in_b[(LW+1)*i]            = ctrl.negate_b & lane_split[i];
      add_in_a[(LW+1)*i+1 +: LW]    = add_op_a[i];
      add_in_b[(LW+1)*i+1 +: LW]    = add_op_b[i];
    end
  end

  assign add_sum = add_in_a + add_in_b;

  // drop the guard bits again
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      ex.adder_res[i] = add_sum[(LW+1)*i+1 +: LW];
    end
  end

  ////////////////////////////////////////
  // shifter
  ////////////////////////////////////////

  logic [XLEN-1:0]   shift_op_a;
  logic [XLEN-1:0]   shift_amt;
  logic [XLEN-1:0]   shift_rgt;
  logic [2*XLEN-1:0] rot_word;

  // left shifts run right on the bit-reversed operand
  assign shift_op_a = ctrl.shift_left ? {<<{operand_a_i}} : operand_a_i;

  // reversing the word also reverses the lane order of the amounts
  always_comb begin
    shift_amt = operand_b_i;
    if (ctrl.shift_left) begin
      if (mode8) begin
        shift_amt = {<<8{operand_b_i}};
      end else if (mode16) begin
        shift_amt = {<<16{operand_b_i}};
      end
    end
  end

  assign rot_word = {shift_op_a, shift_op_a} >> shift_amt[4:0];

  always_comb begin
    shift_rgt = shift_op_a >> shift_amt[4:0];
    if (mode8) begin
      // amount is the low 3 bits of each byte
      for (int i = 0; i < 4; i++) begin
        if (ctrl.shift_arith) begin
          shift_rgt[8*i +: 8] = $unsigned($signed(shift_op_a[8*i +: 8]) >>> shift_amt[8*i +: 3]);
        end else begin
          shift_rgt[8*i +: 8] = shift_op_a[8*i +: 8] >> shift_amt[8*i +: 3];
        end
      end
    end else if (mode16) begin
      // low 4 bits of each half
      for (int h = 0; h < 2; h++) begin
        if (ctrl.shift_arith) begin
          shift_rgt[16*h +: 16] =
            $unsigned($signed(shift_op_a[16*h +: 16]) >>> shift_amt[16*h +: 4]);
        end else begin
          shift_rgt[16*h +: 16] = shift_op_a[16*h +: 16] >> shift_amt[16*h +: 4];
        end
      end
    end else if (ctrl.shift_arith) begin
      shift_rgt = $unsigned($signed(shift_op_a) >>> shift_amt[4:0]);
    end else if (ctrl.rotate) begin
      // rotate only exists for the full word
      shift_rgt = rot_word[XLEN-1:0];
    end
  end

  assign ex.shift_res = ctrl.shift_left ? {<<{shift_rgt}} : shift_rgt;

  ////////////////////////////////////////
  // lane comparator
  ////////////////////////////////////////

  logic [LANES-1:0] eq_byte;
  logic [LANES-1:0] gt_byte;
  logic [LANES-1:0] is_gt;
  logic             top_eq;

  // a ninth bit carries the sign only where the lane top is signed
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      eq_byte[i] = (operand_a_i[i] == operand_b_i[i]);
      gt_byte[i] = $signed({operand_a_i[i][LW-1] & ctrl.cmp_signed[i], operand_a_i[i]}) >
                   $signed({operand_b_i[i][LW-1] & ctrl.cmp_signed[i], operand_b_i[i]});
    end
  end

  // chain the bytes up to the lane width, upper byte decides first
  always_comb begin
    if (mode8) begin
      is_gt  = gt_byte;
      top_eq = eq_byte[3];
    end else if (mode16) begin
      is_gt[1:0] = {2{gt_byte[1] | (eq_byte[1] & gt_byte[0])}};
      is_gt[3:2] = {2{gt_byte[3] | (eq_byte[3] & gt_byte[2])}};
      top_eq     = eq_byte[3] & eq_byte[2];
    end else begin
      is_gt  = {4{gt_byte[3] | (eq_byte[3] & (gt_byte[2] | (eq_byte[2] &
                 (gt_byte[1] | (eq_byte[1] & gt_byte[0])))))}};
      top_eq = &eq_byte;
    end
  end

  assign ex.cmp_flag = ((top_eq & ctrl.cmp_kind[0]) | (is_gt[3] & ctrl.cmp_kind[1]))
                       ^ ctrl.cmp_kind[2];

  ////////////////////////////////////////
  // min, max and abs lane mux
  ////////////////////////////////////////

  alu_pkg::alu_word_t minmax_b;
  logic [LANES-1:0]   pick_a;

  // for abs the other candidate is -a from the adder
  assign minmax_b = ctrl.is_abs ? ex.adder_res : operand_b_i;
  assign pick_a   = is_gt ^ {LANES{ctrl.do_min}};

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      ex.minmax_res[i] = pick_a[i] ? operand_a_i[i] : minmax_b[i];
    end
  end

endmodule

/* rtl/alu_if.sv */
// alu_ctrl_if carries decoded control levels to execute and result
// alu_exec_if carries the datapath results from execute to result

`timescale 1ns/1ps

`include "alu_macros.svh"

////////////////////////////////////////
// decode to execute and result
////////////////////////////////////////

interface alu_ctrl_if;

  // adder operand preparation
  logic negate_b;
  logic negate_a;
  // shifter direction and kind
  logic shift_left;
  logic shift_arith;
  logic rotate;
  // per lane signedness, only the top byte of each lane is set
  logic [`ALU_LANES-1:0] cmp_signed;
  // bit 0 takes equal, bit 1 takes greater, bit 2 inverts the relation
  logic [2:0] cmp_kind;
  logic do_min;
  logic is_abs;
  // 00 and, 01 or, 10 xor
  logic [1:0] logic_kind;
  alu_pkg::res_sel_e res_sel;
  alu_pkg::vec_mode_e vec_mode;

  modport decode (
    output negate_b, negate_a, shift_left, shift_arith, rotate,
    output cmp_signed, cmp_kind, do_min, is_abs, logic_kind, res_sel, vec_mode
  );

  modport execute (
    input negate_b, negate_a, shift_left, shift_arith, rotate,
    input cmp_signed, cmp_kind, do_min, is_abs, logic_kind, vec_mode
  );

  // result only needs the source select
  modport result (input res_sel);

endinterface

////////////////////////////////////////
// execute to result
////////////////////////////////////////

interface alu_exec_if;

  alu_pkg::alu_word_t logic_res;
  alu_pkg::alu_word_t adder_res;
  alu_pkg::alu_word_t shift_res;
  alu_pkg::alu_word_t minmax_res;
  // relation on the top lane
  logic cmp_flag;

  modport execute (output logic_res, adder_res, shift_res, minmax_res, cmp_flag);

  modport result (input logic_res, adder_res, shift_res, minmax_res, cmp_flag);

endinterface

/* rtl/alu_macros.svh */
// word, lane and lane count constants of the simd alu
// shared by the package, the interfaces and the execute stage

`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

////////////////////////////////////////
// datapath geometry
////////////////////////////////////////

// full word width
`define ALU_XLEN   32

// smallest lane, one byte
`define ALU_LANE_W 8

// number of byte lanes in a word
`define ALU_LANES  4

`endif

/* rtl/alu_pkg.sv */
// opcode, vector mode and result source enums of the simd alu
// lane and word types, a word is four byte lanes

`include "alu_macros.svh"

package alu_pkg;

  ////////////////////////////////////////
  // operations
  ////////////////////////////////////////

  // kept opcodes, grouped by datapath
  typedef enum logic [4:0] {
    ALU_AND, ALU_OR, ALU_XOR,
    ALU_ADD, ALU_SUB,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_ROR,
    ALU_EQ, ALU_NE,
    ALU_GTS, ALU_GTU, ALU_GES, ALU_GEU,
    ALU_LTS, ALU_LTU, ALU_LES, ALU_LEU,
    ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU,
    ALU_ABS
  } alu_op_e;

  // vector mode, 2'b01 is reserved
  typedef enum logic [1:0] {
    VEC_MODE32 = 2'b00,
    VEC_MODE16 = 2'b10,
    VEC_MODE8  = 2'b11
  } vec_mode_e;

  // which datapath feeds the result register
  typedef enum logic [2:0] {
    RES_LOGIC,
    RES_ADDER,
    RES_SHIFT,
    RES_CMP,
    RES_MINMAX
  } res_sel_e;

  ////////////////////////////////////////
  // data types
  ////////////////////////////////////////

  typedef logic [`ALU_LANE_W-1:0] alu_lane_t;

  // lane 0 sits in bits 7:0
  typedef alu_lane_t [`ALU_LANES-1:0] alu_word_t;

endpackage

/* rtl/alu_result.sv */
// result stage of the simd alu
// source select and the output registers with the valid strobe

`timescale 1ns/1ps

module alu_result (
  input  logic               clk,
  input  logic               arst_n_i,
  input  logic               valid_i,
  alu_ctrl_if.result         ctrl,
  alu_exec_if.result         ex,
  output alu_pkg::alu_word_t result_o,
  output logic               cmp_o,
  output logic               valid_o
);

  alu_pkg::alu_word_t res_d;

  ////////////////////////////////////////
  // source select
  ////////////////////////////////////////

  always_comb begin
    res_d = '0;
    unique case (ctrl.res_sel)
      alu_pkg::RES_LOGIC:  res_d = ex.logic_res;
      alu_pkg::RES_ADDER:  res_d = ex.adder_res;
      alu_pkg::RES_SHIFT:  res_d = ex.shift_res;
      // flag in bit 0, zeros above
      alu_pkg::RES_CMP:    res_d[0][0] = ex.cmp_flag;
      alu_pkg::RES_MINMAX: res_d = ex.minmax_res;
      default: ;
    endcase
  end

  ////////////////////////////////////////
  // output registers
  ////////////////////////////////////////

  // payload only loads on a valid operation
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      result_o <= '0;
      cmp_o    <= 1'b0;
    end else if (valid_i) begin
      result_o <= res_d;
      cmp_o    <= ex.cmp_flag;
    end
  end

  // strobe follows the input every cycle
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // one cycle latency for every accepted operation
  a_valid_lat : assert property (
    @(posedge clk) disable iff (!arst_n_i)
    valid_i |=> valid_o
  );

  // idle cycle gives no pulse and keeps the last result
  a_idle_hold : assert property (
    @(posedge clk) disable iff (!arst_n_i)
    !valid_i |=> (!valid_o && $stable(result_o) && $stable(cmp_o))
  );

endmodule

/* rtl/alu_top.sv */
// top level of the simd alu
// decode and execute in the sampling cycle, result registered one cycle later

`timescale 1ns/1ps

module alu_top (
  input  logic               clk,
  input  logic               arst_n_i,
  input  logic               valid_i,
  input  alu_pkg::alu_op_e   operator_i,
  input  alu_pkg::vec_mode_e vec_mode_i,
  input  alu_pkg::alu_word_t operand_a_i,
  input  alu_pkg::alu_word_t operand_b_i,
  output alu_pkg::alu_word_t result_o,
  output logic               cmp_o,
  output logic               valid_o
);

  // control levels from decode
  alu_ctrl_if ctrl_if ();
  // datapath results from execute
  alu_exec_if exec_if ();

  alu_decode i_alu_decode (
    .operator_i (operator_i),
    .vec_mode_i (vec_mode_i),
    .valid_i    (valid_i),
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .ctrl       (ctrl_if.decode)
  );

  alu_execute i_alu_execute (
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .ctrl        (ctrl_if.execute),
    .ex          (exec_if.execute)
  );

  // the only state in the design
  alu_result i_alu_result (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .valid_i  (valid_i),
    .ctrl     (ctrl_if.result),
    .ex       (exec_if.result),
    .result_o (result_o),
    .cmp_o    (cmp_o),
    .valid_o  (valid_o)
  );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the alu testbench with verilator, run it, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module alu_top_tb -f alu_top.f \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Valu_top_tb > sim.log 2>&1 ; cat sim.log

grep -qx "Test OK" sim.log && exit 0 || exit 1

/* tests/alu_top_tb.sv */
// testbench of the simd alu top level
// lcg driven random operations, lane model with a one deep expect queue
// directed lane carry checks and a watchdog

`timescale 1ns/1ps

module alu_top_tb;

  localparam int unsigned CLK_NS       = 4;
  localparam int unsigned DRIVE_NS     = 1;
  localparam int unsigned RESET_CYCLES = 3;
  localparam int unsigned N_RAND       = 2000;
  localparam int unsigned N_DIRECTED   = 6;
  // random cycles plus reset, two cycles per directed check and some slack
  localparam int unsigned TIMEOUT_NS   =
    (N_RAND + RESET_CYCLES + 2 * N_DIRECTED + 8) * CLK_NS + 100;

  // one expected output set with the inputs that caused it
  typedef struct packed {
    logic               valid;
    alu_pkg::alu_op_e   op;
    alu_pkg::vec_mode_e mode;
    logic [31:0]        a;
    logic [31:0]        b;
    logic [31:0]        result;
    logic               cmp;
    logic               cmp_care;
  } expect_t;

  logic               clk;
  logic               arst_n;
  logic               valid_i;
  alu_pkg::alu_op_e   operator_i;
  alu_pkg::vec_mode_e vec_mode_i;
  alu_pkg::alu_word_t operand_a_i;
  alu_pkg::alu_word_t operand_b_i;
  alu_pkg::alu_word_t result_o;
  logic               cmp_o;
  logic               valid_o;

  logic [31:0] lcg_state;
  expect_t     exp_q[$];
  // model registers hold while no operation is accepted
  logic [31:0] hold_result;
  logic        hold_cmp;
  logic        hold_cmp_care;
  // last sampled cmp_o for the idle hold check
  logic        last_cmp;

  tb_clk_gen #(.PERIOD_NS(CLK_NS)) i_clk_gen (.clk_o(clk));

  alu_top i_alu_top (
    .clk         (clk),
    .arst_n_i    (arst_n),
    .valid_i     (valid_i),
    .operator_i  (operator_i),
    .vec_mode_i  (vec_mode_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .result_o    (result_o),
    .cmp_o       (cmp_o),
    .valid_o     (valid_o)
  );

  ////////////////////////////////////////
  // random numbers and failure handling
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic end_in_failure();
    $display("Test FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic report_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end_in_failure();
  endtask

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic int lane_bits(alu_pkg::vec_mode_e mode);
    case (mode)
      alu_pkg::VEC_MODE8:  return 8;
      alu_pkg::VEC_MODE16: return 16;
      default:             return 32;
    endcase
  endfunction

  function automatic logic [31:0] lane_mask(int w);
    return 32'((64'd1 << w) - 64'd1);
  endfunction

  // lane as a number with the sign from bit w-1 when asked for
  function automatic longint lane_value(logic [31:0] x, int w, bit sgn);
    longint v;
    v = longint'({32'd0, x});
    if (sgn && x[w-1]) begin
      v = v - (longint'(1) << w);
    end
    return v;
  endfunction

  function automatic bit is_compare(alu_pkg::alu_op_e op);
    return op inside {alu_pkg::ALU_EQ, alu_pkg::ALU_NE, alu_pkg::ALU_GTS, alu_pkg::ALU_GTU,
                      alu_pkg::ALU_GES, alu_pkg::ALU_GEU, alu_pkg::ALU_LTS, alu_pkg::ALU_LTU,
                      alu_pkg::ALU_LES, alu_pkg::ALU_LEU};
  endfunction

  // relation on the top lane only
  function automatic logic model_cmp(alu_pkg::alu_op_e op, alu_pkg::vec_mode_e mode,
                                     logic [31:0] a, logic [31:0] b);
    int          w;
    bit          sgn;
    logic [31:0] m;
    longint      va;
    longint      vb;
    w   = lane_bits(mode);
    m   = lane_mask(w);
    sgn = op inside {alu_pkg::ALU_GTS, alu_pkg::ALU_GES, alu_pkg::ALU_LTS, alu_pkg::ALU_LES};
    va  = lane_value((a >> (32 - w)) & m, w, sgn);
    vb  = lane_value((b >> (32 - w)) & m, w, sgn);
    case (op)
      alu_pkg::ALU_EQ:                   return va == vb;
      alu_pkg::ALU_NE:                   return va != vb;
      alu_pkg::ALU_GTS, alu_pkg::ALU_GTU: return va > vb;
      alu_pkg::ALU_GES, alu_pkg::ALU_GEU: return va >= vb;
      alu_pkg::ALU_LTS, alu_pkg::ALU_LTU: return va < vb;
      alu_pkg::ALU_LES, alu_pkg::ALU_LEU: return va <= vb;
      default:                           return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] model_result(alu_pkg::alu_op_e op, alu_pkg::vec_mode_e mode,
                                              logic [31:0] a, logic [31:0] b);
    int          w;
    int          sh;
    bit          sgn;
    logic [31:0] m;
    logic [31:0] la;
    logic [31:0] lb;
    logic [31:0] r;
    logic [31:0] res;
    longint      va;
    longint      vb;
    if (is_compare(op)) begin
      return {31'd0, model_cmp(op, mode, a, b)};
    end
    w   = lane_bits(mode);
    m   = lane_mask(w);
    res = '0;
    sgn = op inside {alu_pkg::ALU_MIN, alu_pkg::ALU_MAX, alu_pkg::ALU_ABS};
    for (int k = 0; k < 32 / w; k++) begin
      la = (a >> (k * w)) & m;
      lb = (b >> (k * w)) & m;
      // 3, 4 or 5 amount bits taken from the lane itself
      sh = int'(lb) & (w - 1);
      va = lane_value(la, w, sgn);
      vb = lane_value(lb, w, sgn);
      case (op)
        alu_pkg::ALU_AND: r = la & lb;
        alu_pkg::ALU_OR:  r = la | lb;
        alu_pkg::ALU_XOR: r = la ^ lb;
        alu_pkg::ALU_ADD: r = la + lb;
        alu_pkg::ALU_SUB: r = la - lb;
        alu_pkg::ALU_SLL: r = la << sh;
        alu_pkg::ALU_SRL: r = la >> sh;
        alu_pkg::ALU_SRA: r = 32'(lane_value(la, w, 1'b1) >>> sh);
        // a true rotate only for the full word
        alu_pkg::ALU_ROR: r = (w == 32) ? ((la >> sh) | (la << (32 - sh))) : (la >> sh);
        alu_pkg::ALU_MIN, alu_pkg::ALU_MINU: r = (va < vb) ? la : lb;
        alu_pkg::ALU_MAX, alu_pkg::ALU_MAXU: r = (va > vb) ? la : lb;
        alu_pkg::ALU_ABS: r = (va > vb) ? la : -la;
        default:          r = '0;
      endcase
      res = res | ((r & m) << (k * w));
    end
    return res;
  endfunction

  // model of the output registers for one cycle of inputs
  task automatic push_expected(input logic v, input alu_pkg::alu_op_e op,
                               input alu_pkg::vec_mode_e mode, input logic [31:0] a,
                               input logic [31:0] b);
    if (v) begin
      hold_result   = model_result(op, mode, a, b);
      hold_cmp      = model_cmp(op, mode, a, b);
      // cmp_o is only defined by the relation for comparisons
      hold_cmp_care = is_compare(op);
    end
    exp_q.push_back({v, op, mode, a, b, hold_result, hold_cmp, hold_cmp_care});
  endtask

  ////////////////////////////////////////
  // drive and check
  ////////////////////////////////////////

  task automatic check_outputs();
    expect_t e;
    string   ctx;
    e   = exp_q.pop_front();
    ctx = $sformatf("%s %s a=%h b=%h", e.op.name(), e.mode.name(), e.a, e.b);
    assert (valid_o === e.valid)
      else report_value({"valid_o after ", ctx}, 32'(valid_o), 32'(e.valid));
    assert (result_o === e.result)
      else report_value({"result_o of ", ctx}, result_o, e.result);
    if (e.cmp_care) begin
      assert (cmp_o === e.cmp)
        else report_value({"cmp_o of ", ctx}, 32'(cmp_o), 32'(e.cmp));
    end else if (!e.valid) begin
      assert (cmp_o === last_cmp)
        else report_value("cmp_o in an idle cycle", 32'(cmp_o), 32'(last_cmp));
    end
    last_cmp = cmp_o;
  endtask

  // check last cycle's result, then drive the next inputs
  task automatic step(input logic v, input alu_pkg::alu_op_e op,
                      input alu_pkg::vec_mode_e mode, input logic [31:0] a,
                      input logic [31:0] b);
    @(posedge clk);
    #(DRIVE_NS);
    check_outputs();
    valid_i     = v;
    operator_i  = op;
    vec_mode_i  = mode;
    operand_a_i = a;
    operand_b_i = b;
    push_expected(v, op, mode, a, b);
  endtask

  // lane boundary carries against a fixed value
  task automatic check_lane_carry(input alu_pkg::alu_op_e op, input alu_pkg::vec_mode_e mode,
                                  input logic [31:0] a, input logic [31:0] b,
                                  input logic [31:0] expected);
    step(1'b1, op, mode, a, b);
    step(1'b0, op, mode, a, b);
    assert (result_o === expected)
      else report_value($sformatf("lane carry of %s %s", op.name(), mode.name()),
                        result_o, expected);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    logic [31:0]        r;
    logic [31:0]        a;
    logic [31:0]        b;
    logic               v;
    alu_pkg::alu_op_e   op;
    alu_pkg::vec_mode_e mode;

    valid_i       = 1'b0;
    operator_i    = alu_pkg::ALU_AND;
    vec_mode_i    = alu_pkg::VEC_MODE32;
    operand_a_i   = '0;
    operand_b_i   = '0;
    arst_n        = 1'b0;
    lcg_state     = 32'hc9f3_2220;
    hold_result   = '0;
    hold_cmp      = 1'b0;
    hold_cmp_care = 1'b1;
    last_cmp      = 1'b0;

    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_NS);
    assert (valid_o === 1'b0) else report_value("valid_o in reset", 32'(valid_o), 32'd0);
    assert (result_o === '0) else report_value("result_o in reset", result_o, 32'd0);
    assert (cmp_o === 1'b0) else report_value("cmp_o in reset", 32'(cmp_o), 32'd0);
    arst_n = 1'b1;
    push_expected(1'b0, operator_i, vec_mode_i, '0, '0);

    // random regression with valid on about 3 of 4 cycles
    for (int n = 0; n < N_RAND; n++) begin
      r  = lcg_next();
      a  = lcg_next();
      b  = lcg_next();
      v  = (r[31:30] != 2'b00);
      op = alu_pkg::alu_op_e'(5'((r >> 8) % 24));
      case ((r >> 20) % 3)
        0:       mode = alu_pkg::VEC_MODE32;
        1:       mode = alu_pkg::VEC_MODE16;
        default: mode = alu_pkg::VEC_MODE8;
      endcase
      // equal top lanes now and then, so eq and ge paths get hit
      case (r[29:27])
        3'd0:    b = a;
        3'd1:    b[31:16] = a[31:16];
        3'd2:    b[31:24] = a[31:24];
        default: ;
      endcase
      step(v, op, mode, a, b);
    end

    // no carry may cross a lane edge
    check_lane_carry(alu_pkg::ALU_ADD, alu_pkg::VEC_MODE8, 32'hffff_ffff, 32'hffff_ffff,
                     32'hfefe_fefe);
    check_lane_carry(alu_pkg::ALU_ADD, alu_pkg::VEC_MODE16, 32'hffff_ffff, 32'hffff_ffff,
                     32'hfffe_fffe);
    check_lane_carry(alu_pkg::ALU_ADD, alu_pkg::VEC_MODE8, 32'hffff_ffff, 32'h0101_0101,
                     32'h0000_0000);
    check_lane_carry(alu_pkg::ALU_ADD, alu_pkg::VEC_MODE16, 32'hffff_ffff, 32'h0001_0001,
                     32'h0000_0000);
    check_lane_carry(alu_pkg::ALU_ADD, alu_pkg::VEC_MODE32, 32'hffff_ffff, 32'h0000_0001,
                     32'h0000_0000);
    check_lane_carry(alu_pkg::ALU_SUB, alu_pkg::VEC_MODE8, 32'h0000_0000, 32'h0101_0101,
                     32'hffff_ffff);

    step(1'b0, alu_pkg::ALU_AND, alu_pkg::VEC_MODE32, '0, '0);

    $display("Test OK");
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("timeout, the run did not reach its end within %0d ns", TIMEOUT_NS);
    end_in_failure();
  end

endmodule

/* tests/tb_clk_gen.sv */
// free running clock for the alu testbench
// 50 percent duty cycle, starts low

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS = 4
) (
  output logic clk_o
);

  // toggle every half period
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk_o = ~clk_o;
    end
  end

endmodule
